//--- Makefile
VERILATOR ?= verilator
TOP       := sweepAcqTb
RTL_TOP   := sweepAcqTop
FLIST     := flist.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ns -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
FAIL_MSG  := ** FAIL **
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
+incdir+source
source/sweepTypesPkg.sv
source/sweepCtrlPkg.sv
source/eventFramer.sv
source/eventFifo.sv
source/sweepSequencer.sv
source/wordOutput.sv
source/sweepAcqTop.sv
test/sweepAcq_chk.sv
test/sweepAcqMonitor.sv
test/sweepAcqTb.sv

//--- source/eventFifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "sweep_cfg.svh"

module eventFifo
    import sweepTypesPkg::*;
(
    input  logic      Clk,
    input  logic      reset_n,
    input  logic      write,
    input  dataWord_t writeData,
    input  logic      read,
    output dataWord_t readData,
    output logic      overflow
);

    localparam int addrW = `SWEEP_FIFO_DEPTH_LOG2;
    localparam int depth = 1 << addrW;

    dataWord_t mem [depth];

    // Extra MSB tells full from empty
    logic [addrW:0] wrPtr;
    logic [addrW:0] rdPtr;
    logic           empty;
    logic           full;

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[addrW] != rdPtr[addrW]) && (wrPtr[addrW-1:0] == rdPtr[addrW-1:0]);

    // Pointers and sticky overflow
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            overflow <= 1'b0;
        end else begin
            if (write && !full) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (write && full) begin
                overflow <= 1'b1;
            end
            if (read && !empty) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // Storage and registered read, data valid the cycle after read
    always_ff @(posedge Clk) begin
        if (write && !full) begin
            mem[wrPtr[addrW-1:0]] <= writeData;
        end
        if (read && !empty) begin
            readData <= mem[rdPtr[addrW-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- source/eventFramer.sv
`timescale 1ns/1ns
`default_nettype none

`include "sweep_cfg.svh"

module eventFramer
    import sweepTypesPkg::*;
(
    input  logic      Clk,
    input  logic      reset_n,
    input  logic      ParallelData_en,
    input  dataWord_t ParallelData,
    output logic      fifoWrite,
    output dataWord_t fifoData,
    output logic      eventReady
);

    // Position of the next strobed word in its event
    wordCount_t wordIdx;
    logic       lastWord;

    assign lastWord = (wordIdx == wordCount_t'(`SWEEP_EVENT_WORDS - 1));

    //////////////////////////////
    // Word counter
    //////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wordIdx    <= '0;
            eventReady <= 1'b0;
        end else begin
            eventReady <= 1'b0;
            // Holds while no strobe
            if (ParallelData_en) begin
                if (lastWord) begin
                    wordIdx    <= '0;
                    // Aligned with the FIFO write of the tenth word
                    eventReady <= 1'b1;
                end else begin
                    wordIdx <= wordIdx + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // FIFO write port
    //////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            fifoWrite <= 1'b0;
        end else begin
            fifoWrite <= ParallelData_en;
        end
    end

    // Data only, the write strobe qualifies it
    always_ff @(posedge Clk) begin
        if (ParallelData_en) begin
            fifoData <= ParallelData;
        end
    end

endmodule

`default_nettype wire

//--- source/sweepAcqTop.sv
`timescale 1ns/1ns
`default_nettype none

module sweepAcqTop
    import sweepTypesPkg::*;
    import sweepCtrlPkg::*;
(
    input  logic      Clk,
    input  logic      reset_n,
    // Sweep control
    input  logic      SweepStart,
    input  dacCode_t  StartDac0,
    input  dacCode_t  EndDac0,
    input  pkgCount_t MaxPackageNumber,
    output logic      OneDacDone,
    output logic      AcqDone,
    input  logic      DataTransmitDone,
    // Chip side
    input  logic      ParallelData_en,
    input  dataWord_t ParallelData,
    output dacCode_t  OutDac0,
    output logic      LoadScParameter,
    input  logic      MicrorocConfigDone,
    output logic      ForceAcqReset,
    output logic      SingleAcqStart,
    // USB side
    input  logic      UsbFull,
    output dataWord_t SweepAcqData,
    output logic      SweepAcqData_en,
    output logic      FifoOverflow
);

    sweepCfg_t cfg;
    outWord_t  outWord;
    logic      fifoWrite;
    dataWord_t fifoWriteData;
    logic      fifoRead;
    dataWord_t fifoReadData;
    logic      eventReady;

    assign cfg = '{startDac: StartDac0, endDac: EndDac0, maxPackages: MaxPackageNumber};

    //////////////////////////////
    // Input side
    //////////////////////////////
    eventFramer u_eventFramer (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .ParallelData_en (ParallelData_en),
        .ParallelData    (ParallelData),
        .fifoWrite       (fifoWrite),
        .fifoData        (fifoWriteData),
        .eventReady      (eventReady)
    );

    eventFifo u_eventFifo (
        .Clk       (Clk),
        .reset_n   (reset_n),
        .write     (fifoWrite),
        .writeData (fifoWriteData),
        .read      (fifoRead),
        .readData  (fifoReadData),
        .overflow  (FifoOverflow)
    );

    // Sweep control and DAC loop
    sweepSequencer u_sweepSequencer (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .SweepStart         (SweepStart),
        .cfg                (cfg),
        .eventReady         (eventReady),
        .fifoRead           (fifoRead),
        .fifoData           (fifoReadData),
        .MicrorocConfigDone (MicrorocConfigDone),
        .usbFull            (UsbFull),
        .DataTransmitDone   (DataTransmitDone),
        .OutDac0            (OutDac0),
        .LoadScParameter    (LoadScParameter),
        .ForceAcqReset      (ForceAcqReset),
        .SingleAcqStart     (SingleAcqStart),
        .OneDacDone         (OneDacDone),
        .AcqDone            (AcqDone),
        .outWord            (outWord)
    );

    // Output register toward USB
    wordOutput u_wordOutput (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .outWord         (outWord),
        .SweepAcqData    (SweepAcqData),
        .SweepAcqData_en (SweepAcqData_en)
    );

endmodule

`default_nettype wire

//--- source/sweepCtrlPkg.sv
`default_nettype none

package sweepCtrlPkg;

    import sweepTypesPkg::*;

    // Sweep sequencer states
    typedef enum logic [3:0] {
        IDLE,
        HEADER,
        PARAM,
        LOAD,
        WAIT_CFG,
        SETTLE,
        START,
        WAIT_EVENT,
        READ,
        OUTWORD,
        NEXT_EVENT,
        NEXT_DAC,
        TAIL,
        DONE
    } seqState_t;

    // Sweep range and events per code
    typedef struct packed {
        dacCode_t  startDac;
        dacCode_t  endDac;
        pkgCount_t maxPackages;
    } sweepCfg_t;

    // Word handed to the output stage
    typedef struct packed {
        logic      valid;
        dataWord_t data;
    } outWord_t;

endpackage

`default_nettype wire

//--- source/sweepSequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "sweep_cfg.svh"

module sweepSequencer
    import sweepTypesPkg::*;
    import sweepCtrlPkg::*;
(
    input  logic      Clk,
    input  logic      reset_n,
    input  logic      SweepStart,
    input  sweepCfg_t cfg,
    input  logic      eventReady,
    output logic      fifoRead,
    input  dataWord_t fifoData,
    input  logic      MicrorocConfigDone,
    input  logic      usbFull,
    input  logic      DataTransmitDone,
    output dacCode_t  OutDac0,
    output logic      LoadScParameter,
    output logic      ForceAcqReset,
    output logic      SingleAcqStart,
    output logic      OneDacDone,
    output logic      AcqDone,
    output outWord_t  outWord
);

    localparam int settleW = $clog2(`SWEEP_SETTLE_CYCLES + 1);

    seqState_t          state;
    dacCode_t           currentDac;
    pkgCount_t          eventCount;
    pkgCount_t          pending;
    wordCount_t         wordIdx;
    logic [settleW-1:0] settleCount;
    logic               cfgSeen;
    logic               eventTake;

    // Chip config port expects MSB and LSB swapped
    function automatic dacCode_t reverseDac(input dacCode_t code);
        dacCode_t rev;
        for (int i = 0; i < `SWEEP_DAC_W; i++) begin
            rev[i] = code[`SWEEP_DAC_W-1-i];
        end
        return rev;
    endfunction

    // One read per word, never into a full USB FIFO
    assign fifoRead  = (state == READ) && !usbFull;
    // First read of an event takes it off the pending count
    assign eventTake = fifoRead && (wordIdx == '0);

    //////////////////////////////
    // Pending event counter
    //////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= '0;
        end else begin
            case ({eventReady, eventTake})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    //////////////////////////////
    // Sweep FSM
    //////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= IDLE;
            currentDac      <= '0;
            eventCount      <= '0;
            wordIdx         <= '0;
            settleCount     <= '0;
            cfgSeen         <= 1'b0;
            OutDac0         <= '0;
            LoadScParameter <= 1'b0;
            ForceAcqReset   <= 1'b0;
            SingleAcqStart  <= 1'b0;
            OneDacDone      <= 1'b0;
            AcqDone         <= 1'b0;
            outWord         <= '0;
        end else begin
            // Pulses by default
            LoadScParameter <= 1'b0;
            ForceAcqReset   <= 1'b0;
            OneDacDone      <= 1'b0;
            outWord.valid   <= 1'b0;
            case (state)
                IDLE: begin
                    if (SweepStart) begin
                        currentDac <= cfg.startDac;
                        outWord    <= '{valid: 1'b1, data: `SWEEP_HEADER};
                        state      <= HEADER;
                    end
                end
                HEADER: state <= PARAM;
                PARAM: begin
                    outWord <= '{valid: 1'b1, data: {`SWEEP_PARAM_TAG, 2'b00, currentDac}};
                    OutDac0 <= reverseDac(currentDac);
                    state   <= LOAD;
                end
                LOAD: begin
                    LoadScParameter <= 1'b1;
                    cfgSeen         <= 1'b0;
                    state           <= WAIT_CFG;
                end
                WAIT_CFG: begin
                    // Wait for config done to rise, then fall
                    if (MicrorocConfigDone) begin
                        cfgSeen <= 1'b1;
                    end else if (cfgSeen) begin
                        settleCount <= '0;
                        state       <= SETTLE;
                    end
                end
                SETTLE: begin
                    if (settleCount == settleW'(`SWEEP_SETTLE_CYCLES - 1)) begin
                        ForceAcqReset <= 1'b1;
                        state         <= START;
                    end else begin
                        settleCount <= settleCount + 1'b1;
                    end
                end
                START: begin
                    SingleAcqStart <= 1'b1;
                    eventCount     <= '0;
                    state          <= WAIT_EVENT;
                end
                WAIT_EVENT: begin
                    if (pending != '0) begin
                        wordIdx <= '0;
                        state   <= READ;
                    end
                end
                // Stalls here under USB back-pressure
                READ: if (!usbFull) state <= OUTWORD;
                OUTWORD: begin
                    outWord <= '{valid: 1'b1, data: fifoData};
                    if (wordIdx == wordCount_t'(`SWEEP_EVENT_WORDS - 1)) begin
                        state <= NEXT_EVENT;
                    end else begin
                        wordIdx <= wordIdx + 1'b1;
                        state   <= READ;
                    end
                end
                NEXT_EVENT: begin
                    if (eventCount + 1'b1 >= cfg.maxPackages) begin
                        SingleAcqStart <= 1'b0;
                        OneDacDone     <= 1'b1;
                        state          <= NEXT_DAC;
                    end else begin
                        eventCount <= eventCount + 1'b1;
                        state      <= WAIT_EVENT;
                    end
                end
                NEXT_DAC: begin
                    if (currentDac < cfg.endDac) begin
                        currentDac <= currentDac + 1'b1;
                        state      <= PARAM;
                    end else begin
                        outWord <= '{valid: 1'b1, data: `SWEEP_TAIL};
                        state   <= TAIL;
                    end
                end
                TAIL: state <= DONE;
                DONE: begin
                    // Raised once the tail word is out
                    if (DataTransmitDone) begin
                        AcqDone <= 1'b0;
                        state   <= IDLE;
                    end else begin
                        AcqDone <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/sweepTypesPkg.sv
`default_nettype none

`include "sweep_cfg.svh"

package sweepTypesPkg;

    // DAC0 threshold code
    typedef logic [`SWEEP_DAC_W-1:0] dacCode_t;

    // Chip data and output stream word
    typedef logic [`SWEEP_WORD_W-1:0] dataWord_t;

    // Events per DAC code
    typedef logic [`SWEEP_PKG_W-1:0] pkgCount_t;

    // Word index inside one event
    typedef logic [3:0] wordCount_t;

endpackage

`default_nettype wire

//--- source/sweep_cfg.svh
`ifndef SWEEP_CFG_SVH
`define SWEEP_CFG_SVH

//////////////////////////////
// Widths
//////////////////////////////
`define SWEEP_WORD_W 16
`define SWEEP_DAC_W 10
`define SWEEP_PKG_W 16

// Chip event size in words
`define SWEEP_EVENT_WORDS 10
// Delay after config done, short value for simulation
`define SWEEP_SETTLE_CYCLES 40
`define SWEEP_FIFO_DEPTH_LOG2 5

//////////////////////////////
// Marker words
//////////////////////////////
`define SWEEP_HEADER 16'h5341
`define SWEEP_TAIL 16'hFF45
`define SWEEP_PARAM_TAG 4'hD

`endif

//--- source/wordOutput.sv
`timescale 1ns/1ns
`default_nettype none

module wordOutput
    import sweepTypesPkg::*;
    import sweepCtrlPkg::*;
(
    input  logic      Clk,
    input  logic      reset_n,
    input  outWord_t  outWord,
    output dataWord_t SweepAcqData,
    output logic      SweepAcqData_en
);

    //////////////////////////////
    // Output register
    //////////////////////////////

    // One enable cycle per word from the sequencer
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            SweepAcqData_en <= 1'b0;
        end else begin
            SweepAcqData_en <= outWord.valid;
        end
    end

    // Last word stays on the bus until the next one,
    // so a stalled USB side still sees stable data
    always_ff @(posedge Clk) begin
        if (outWord.valid) begin
            SweepAcqData <= outWord.data;
        end
    end

endmodule

`default_nettype wire

//--- test/sweepAcqMonitor.sv
`timescale 1ns/1ns
`default_nettype none

`include "sweep_cfg.svh"

module sweepAcqMonitor
    import sweepTypesPkg::*;
(
    input logic      Clk,
    input logic      reset_n,
    input logic      SweepAcqData_en,
    input dataWord_t SweepAcqData,
    input logic      LoadScParameter,
    input dacCode_t  OutDac0,
    input logic      AcqDone,
    input logic      OneDacDone,
    input logic      FifoOverflow,
    input pkgCount_t MaxPackageNumber
);

    // Kind tag in the top two bits of a queue entry
    localparam logic [1:0] kindHeader = 2'd0;
    localparam logic [1:0] kindParam  = 2'd1;
    localparam logic [1:0] kindTail   = 2'd3;
    localparam int eventWords = `SWEEP_EVENT_WORDS;

    // Filled by the testbench in stream order
    logic [17:0] expectQ [$];
    string       testName = "none";
    int          errorCount = 0;
    int          wordsChecked = 0;

    dacCode_t    paramCode = '0;
    // Output words since the last parameter word
    int          dacWordCount = 0;
    logic        dacDoneSeen = 1'b0;
    logic        inDac = 1'b0;
    logic        tailSeen = 1'b0;
    logic        acqDonePrev = 1'b0;
    logic        overflowSeen = 1'b0;

    // LSB of the code ends up as MSB
    function automatic dacCode_t reverseBits(input dacCode_t code);
        dacCode_t result;
        result = '0;
        for (int i = 0; i < $bits(dacCode_t); i++) begin
            result = {result[$bits(dacCode_t)-2:0], code[i]};
        end
        return result;
    endfunction

    //////////////////////////////
    // Word stream compare
    //////////////////////////////
    task automatic checkWord();
        logic [17:0] entry;
        if (expectQ.size() == 0) begin
            $display("Unexpected output word %h in test %s", SweepAcqData, testName);
            errorCount++;
            return;
        end
        entry = expectQ.pop_front();
        wordsChecked++;
        if (SweepAcqData !== entry[15:0]) begin
            $display("Fail %s: output word %0d expected %h actual %h",
                     testName, wordsChecked, entry[15:0], SweepAcqData);
            errorCount++;
        end
        if (entry[17:16] == kindParam || entry[17:16] == kindTail) begin
            // Previous code must have closed with OneDacDone
            if (inDac && !dacDoneSeen) begin
                $display("OneDacDone did not pulse in test %s for DAC %h",
                         testName, paramCode);
                errorCount++;
            end
            inDac       = (entry[17:16] == kindParam);
            tailSeen    = (entry[17:16] == kindTail);
            paramCode   = entry[`SWEEP_DAC_W-1:0];
            dacDoneSeen = 1'b0;
        end else if (entry[17:16] == kindHeader) begin
            inDac    = 1'b0;
            tailSeen = 1'b0;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge Clk) begin
        if (reset_n) begin
            if (SweepAcqData_en) begin
                checkWord();
                dacWordCount++;
            end
            // Param word and load strobe share a cycle
            if (LoadScParameter) begin
                if (OutDac0 !== reverseBits(paramCode)) begin
                    $display("Fail %s: OutDac0 expected %h actual %h",
                             testName, reverseBits(paramCode), OutDac0);
                    errorCount++;
                end
                dacWordCount = 0;
            end
            // Event words of one code end with OneDacDone
            if (OneDacDone) begin
                dacDoneSeen = 1'b1;
                if (dacWordCount != eventWords * int'(MaxPackageNumber)) begin
                    $display("Fail %s: event words for DAC %h expected %0d actual %0d",
                             testName, paramCode, eventWords * int'(MaxPackageNumber),
                             dacWordCount);
                    errorCount++;
                end
            end
            if (AcqDone && !acqDonePrev && !tailSeen) begin
                $display("AcqDone rose in test %s before the tail word was sent", testName);
                errorCount++;
            end
            if (FifoOverflow && !overflowSeen) begin
                $display("FifoOverflow went high in test %s, event data was lost", testName);
                errorCount++;
            end
            overflowSeen = FifoOverflow;
            acqDonePrev  = AcqDone;
        end
    end

endmodule

`default_nettype wire

//--- test/sweepAcqTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "sweep_cfg.svh"

module sweepAcqTb
    import sweepTypesPkg::*;
();

    localparam int numTests = 4;
    localparam int waitLimit = 2000;
    localparam int eventGap = 40;
    localparam logic [31:0] lcgSeed = 32'hedb9_481a;

    // Same kind tags as the monitor queue
    localparam logic [1:0] kindHeader = 2'd0;
    localparam logic [1:0] kindParam  = 2'd1;
    localparam logic [1:0] kindEvent  = 2'd2;
    localparam logic [1:0] kindTail   = 2'd3;

    // Selectors for waitLevel
    localparam int sigLoad  = 0;
    localparam int sigStart = 1;
    localparam int sigDone  = 2;

    typedef struct packed {
        dacCode_t  startDac;
        dacCode_t  endDac;
        pkgCount_t maxPackages;
        logic      usbRandom;
    } testRow_t;

    // Columns: startDac, endDac, maxPackages, random usbFull
    testRow_t testTable [numTests] = '{
        '{10'h005, 10'h005, 16'd1, 1'b0},
        '{10'h012, 10'h014, 16'd2, 1'b0},
        '{10'h3FD, 10'h3FF, 16'd2, 1'b1},
        '{10'h200, 10'h201, 16'd4, 1'b1}
    };
    string testNames [numTests] = '{"oneCode", "threeCodes", "usbBackPressure", "fourEvents"};

    logic        Clk = 1'b0;
    logic        reset_n;
    logic        SweepStart;
    dacCode_t    StartDac0;
    dacCode_t    EndDac0;
    pkgCount_t   MaxPackageNumber;
    logic        DataTransmitDone;
    logic        ParallelData_en;
    dataWord_t   ParallelData;
    logic        MicrorocConfigDone;
    logic        UsbFull = 1'b0;
    dacCode_t    OutDac0;
    logic        OneDacDone;
    logic        AcqDone;
    logic        LoadScParameter;
    logic        ForceAcqReset;
    logic        SingleAcqStart;
    dataWord_t   SweepAcqData;
    logic        SweepAcqData_en;
    logic        FifoOverflow;

    logic [31:0] dataState = lcgSeed;
    logic [31:0] fullState = lcgSeed;
    logic        usbRandom = 1'b0;
    logic        timeoutHit = 1'b0;
    int          tbErrors = 0;

    always #20 Clk = ~Clk;

    sweepAcqTop u_sweepAcqTop (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .SweepStart         (SweepStart),
        .StartDac0          (StartDac0),
        .EndDac0            (EndDac0),
        .MaxPackageNumber   (MaxPackageNumber),
        .OneDacDone         (OneDacDone),
        .AcqDone            (AcqDone),
        .DataTransmitDone   (DataTransmitDone),
        .ParallelData_en    (ParallelData_en),
        .ParallelData       (ParallelData),
        .OutDac0            (OutDac0),
        .LoadScParameter    (LoadScParameter),
        .MicrorocConfigDone (MicrorocConfigDone),
        .ForceAcqReset      (ForceAcqReset),
        .SingleAcqStart     (SingleAcqStart),
        .UsbFull            (UsbFull),
        .SweepAcqData       (SweepAcqData),
        .SweepAcqData_en    (SweepAcqData_en),
        .FifoOverflow       (FifoOverflow)
    );

    sweepAcqMonitor u_monitor (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .SweepAcqData_en  (SweepAcqData_en),
        .SweepAcqData     (SweepAcqData),
        .LoadScParameter  (LoadScParameter),
        .OutDac0          (OutDac0),
        .AcqDone          (AcqDone),
        .OneDacDone       (OneDacDone),
        .FifoOverflow     (FifoOverflow),
        .MaxPackageNumber (MaxPackageNumber)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] prev);
        return prev * 32'd1664525 + 32'd1013904223;
    endfunction

    // Tag, two zero bits, then the code
    function automatic logic [17:0] paramEntry(input dacCode_t code);
        return {kindParam, `SWEEP_PARAM_TAG, 2'b00, code};
    endfunction

    function automatic logic sigValue(input int sel);
        case (sel)
            sigLoad:  return LoadScParameter;
            sigStart: return SingleAcqStart;
            default:  return AcqDone;
        endcase
    endfunction

    function automatic int totalErrors();
        return tbErrors + u_monitor.errorCount
            + u_sweepAcqTop.u_sweepSequencer.u_chk.assertFails;
    endfunction

    //////////////////////////////
    // USB back-pressure
    //////////////////////////////
    always @(negedge Clk) begin
        fullState = lcgNext(fullState);
        UsbFull   = usbRandom ? fullState[31] : 1'b0;
    end

    // Polls at each falling edge
    task automatic waitLevel(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        while (sigValue(sel) !== level && cycles < waitLimit) begin
            @(negedge Clk);
            cycles++;
        end
        if (sigValue(sel) !== level) begin
            $display("Timeout: %s did not happen within %0d cycles", what, waitLimit);
            timeoutHit = 1'b1;
            tbErrors++;
        end
    endtask

    //////////////////////////////
    // Chip emulation
    //////////////////////////////
    // Config done level of a few cycles
    task automatic answerConfig();
        MicrorocConfigDone = 1'b1;
        repeat (3) @(negedge Clk);
        MicrorocConfigDone = 1'b0;
    endtask

    // Ten back-to-back strobed LCG words
    task automatic sendEvent();
        for (int w = 0; w < `SWEEP_EVENT_WORDS; w++) begin
            dataState       = lcgNext(dataState);
            ParallelData_en = 1'b1;
            ParallelData    = dataState[31:16];
            u_monitor.expectQ.push_back({kindEvent, dataState[31:16]});
            @(negedge Clk);
        end
        ParallelData_en = 1'b0;
    endtask

    task automatic runTest(input int idx);
        testRow_t row;
        row              = testTable[idx];
        usbRandom        = row.usbRandom;
        u_monitor.testName = testNames[idx];
        StartDac0        = row.startDac;
        EndDac0          = row.endDac;
        MaxPackageNumber = row.maxPackages;
        u_monitor.expectQ.push_back({kindHeader, `SWEEP_HEADER});
        u_monitor.expectQ.push_back(paramEntry(row.startDac));
        SweepStart = 1'b1;
        @(negedge Clk);
        SweepStart = 1'b0;
        for (int d = int'(row.startDac); d <= int'(row.endDac); d++) begin
            waitLevel(sigLoad, 1'b1, "LoadScParameter pulse");
            if (timeoutHit) return;
            answerConfig();
            waitLevel(sigStart, 1'b1, "SingleAcqStart rise");
            if (timeoutHit) return;
            for (int e = 0; e < int'(row.maxPackages); e++) begin
                // Gap lets the FIFO drain between events
                if (e > 0) repeat (eventGap) @(negedge Clk);
                sendEvent();
            end
            if (d == int'(row.endDac)) begin
                u_monitor.expectQ.push_back({kindTail, `SWEEP_TAIL});
            end else begin
                u_monitor.expectQ.push_back(paramEntry(dacCode_t'(d + 1)));
            end
            waitLevel(sigStart, 1'b0, "SingleAcqStart fall");
            if (timeoutHit) return;
        end
        waitLevel(sigDone, 1'b1, "AcqDone rise");
        if (timeoutHit) return;
        if (u_monitor.expectQ.size() != 0) begin
            $display("Test %s ended with %0d expected words never sent",
                     testNames[idx], u_monitor.expectQ.size());
            tbErrors++;
        end
        // AcqDone drops one cycle after the handshake
        DataTransmitDone = 1'b1;
        @(negedge Clk);
        DataTransmitDone = 1'b0;
        if (AcqDone !== 1'b0) begin
            $display("Fail %s: AcqDone after DataTransmitDone expected 0 actual %b",
                     testNames[idx], AcqDone);
            tbErrors++;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int errorsBefore;
        int testErrors;
        int testsRun;
        int testsFailed;
        testsRun           = 0;
        testsFailed        = 0;
        reset_n            = 1'b0;
        SweepStart         = 1'b0;
        StartDac0          = '0;
        EndDac0            = '0;
        MaxPackageNumber   = '0;
        DataTransmitDone   = 1'b0;
        ParallelData_en    = 1'b0;
        ParallelData       = '0;
        MicrorocConfigDone = 1'b0;
        repeat (4) @(negedge Clk);
        reset_n = 1'b1;
        repeat (2) @(negedge Clk);
        for (int i = 0; i < numTests; i++) begin
            if (!timeoutHit) begin
                errorsBefore = totalErrors();
                runTest(i);
                repeat (4) @(negedge Clk);
                testErrors = totalErrors() - errorsBefore;
                testsRun++;
                if (testErrors == 0) begin
                    $display("Test %s passed", testNames[i]);
                end else begin
                    $display("Test %s failed with %0d errors", testNames[i], testErrors);
                    testsFailed++;
                end
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d, output words checked %0d",
                 testsRun, testsRun - testsFailed, testsFailed, u_monitor.wordsChecked);
        if (testsFailed == 0 && testsRun == numTests && totalErrors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/sweepAcq_chk.sv
`timescale 1ns/1ns
`default_nettype none

module sweepAcq_chk
    import sweepCtrlPkg::*;
(
    input logic      Clk,
    input logic      reset_n,
    input seqState_t state,
    input logic      LoadScParameter,
    input logic      ForceAcqReset,
    input logic      SingleAcqStart,
    input logic      fifoRead,
    input logic      usbFull,
    input outWord_t  outWord
);

    // Failing assertions so far, read by the testbench
    int assertFails = 0;

    //////////////////////////////
    // Strobe widths
    //////////////////////////////
    loadOneCycle: assert property (@(posedge Clk) disable iff (!reset_n)
        LoadScParameter |=> !LoadScParameter)
        else begin
            assertFails++;
            $error("LoadScParameter high for more than one cycle");
        end

    resetOneCycle: assert property (@(posedge Clk) disable iff (!reset_n)
        ForceAcqReset |=> !ForceAcqReset)
        else begin
            assertFails++;
            $error("ForceAcqReset high for more than one cycle");
        end

    //////////////////////////////
    // Protocol
    //////////////////////////////
    // Acquisition never runs while the sweep is idle
    idleNoAcq: assert property (@(posedge Clk) disable iff (!reset_n)
        (state == IDLE) |-> !SingleAcqStart)
        else begin
            assertFails++;
            $error("SingleAcqStart high in IDLE");
        end

    // Every FIFO read reaches the output stage
    readToWord: assert property (@(posedge Clk) disable iff (!reset_n)
        fifoRead |=> ##1 outWord.valid)
        else begin
            assertFails++;
            $error("FIFO read not followed by an output word");
        end

endmodule

bind sweepSequencer sweepAcq_chk u_chk (.*);

`default_nettype wire
